// ==== vlog.f ====
+incdir+include
hdl/lsu_pkg.sv
hdl/mem_req_if.sv
hdl/lsu_tag_if.sv
hdl/lsu_issue.sv
hdl/mem_delayed.sv
hdl/lsu_format.sv
hdl/lsu_top.sv
tests/tb_clk_gen.sv
tests/lsu_chk.sv
tests/tb_lsu.sv

// ==== Bender.yml ====
package:
  name: lsu_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/lsu_pkg.sv
      - hdl/mem_req_if.sv
      - hdl/lsu_tag_if.sv
      - hdl/lsu_issue.sv
      - hdl/mem_delayed.sv
      - hdl/lsu_format.sv
      - hdl/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clk_gen.sv
      - tests/lsu_chk.sv
      - tests/tb_lsu.sv

// ==== tests/tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu;
    import lsu_pkg::*;

    localparam int mem_delay  = `LSU_MEM_DELAY;
    localparam int idx_w      = $clog2(`LSU_MEM_WORDS);
    localparam int resp_limit = mem_delay + 20;
    localparam int n_pairs    = 32;
    localparam int n_sub      = 64;
    localparam int n_mis      = 16;
    localparam int n_mix      = 200;
    localparam int n_ops_all  = `LSU_MEM_WORDS + 2 * n_pairs + n_sub + 2 * n_mis + n_mix;
    // preload takes one cycle per word on top of the operations themselves
    localparam int wd_cycles  = n_ops_all * (mem_delay + 4) * 3 / 2 + 2 * `LSU_MEM_WORDS;

    logic    clk;
    logic    rst;
    logic    hold_rst;
    logic    req_valid;
    mem_op_e req_op;
    addr_t   req_addr;
    word_t   req_wdata;
    logic    req_ready;
    logic    resp_valid;
    word_t   resp_data;
    logic    resp_err;
    logic    oob_wen;
    addr_t   oob_addr;
    word_t   oob_data;

    word_t       model_mem [`LSU_MEM_WORDS];
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          ops_done;
    int          tests_run;
    int          err_mark;
    int          op_mark;

    mem_op_e sub_ops [4] = '{OP_LB, OP_LBU, OP_LH, OP_LHU};
    mem_op_e mis_ops [4] = '{OP_LH, OP_LHU, OP_LW, OP_SW};

    tb_clk_gen #(.period_ns(20), .rst_cycles(16)) i_clk_gen (
        .clk      (clk),
        .rst      (rst),
        .hold_rst (hold_rst)
    );

    lsu_top #(.mem_delay(mem_delay)) i_lsu_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_err   (resp_err),
        .oob_wen    (oob_wen),
        .oob_addr   (oob_addr),
        .oob_data   (oob_data)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 16); // fold the better upper bits down
    endfunction

    function automatic addr_t rand_word_addr();
        logic [31:0] r;
        addr_t       a;
        r = lcg_next();
        a = '0;
        a[idx_w+1:2] = r[idx_w+7:8];
        return a;
    endfunction

    function automatic logic expect_misaligned(mem_op_e op, logic [1:0] off);
        if (op == OP_LH || op == OP_LHU)
            return off[0];
        if (op == OP_LW || op == OP_SW)
            return off != 2'b00;
        return 1'b0;
    endfunction

    // little-endian lane pick, then sign or zero extension
    function automatic word_t load_result(mem_op_e op, word_t w, logic [1:0] off);
        word_t       by_byte;
        word_t       by_half;
        logic [7:0]  b;
        logic [15:0] h;
        by_byte = w >> {off, 3'b000};
        by_half = w >> {off[1], 4'b0000};
        b = by_byte[7:0];
        h = by_half[15:0];
        case (op)
            OP_LB:   return 32'($signed(b));
            OP_LBU:  return 32'(b);
            OP_LH:   return 32'($signed(h));
            OP_LHU:  return 32'(h);
            OP_LW:   return w;
            default: return '0;
        endcase
    endfunction

    task automatic model_apply(input mem_op_e op, input addr_t a, input word_t d,
                               output word_t data, output logic err);
        err  = expect_misaligned(op, a[1:0]);
        data = '0;
        if (!err && op == OP_SW)
            model_mem[a[idx_w+1:2]] = d;
        else if (!err)
            data = load_result(op, model_mem[a[idx_w+1:2]], a[1:0]);
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %0d cycles expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic drive_req(input mem_op_e op, input addr_t a, input word_t d);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = a;
        req_wdata = d;
    endtask

    task automatic pick_random_op(output mem_op_e op, output addr_t a, output word_t d);
        logic [31:0] r;
        r  = lcg_next();
        op = mem_op_e'(r[18:16] % 3'd6);
        a  = rand_word_addr();
        if (!r[23])
            a[1:0] = r[21:20];
        d = lcg_next();
    endtask

    // one operation alone, timed from the accepting edge to resp_valid
    task automatic run_op(input mem_op_e op, input addr_t a, input word_t d);
        word_t exp_data;
        logic  exp_err;
        int    cycles;
        int    ready_at;
        int    exp_lat;
        string ctx;
        model_apply(op, a, d, exp_data, exp_err);
        exp_lat = exp_err ? 2 : mem_delay + 3;
        ctx = $sformatf("%s at %h", op.name(), a);
        @(negedge clk);
        drive_req(op, a, d);
        cycles = 0;
        while (!req_ready && cycles < resp_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!req_ready) begin
            errors++;
            $display("%s was never accepted because req_ready stayed low", ctx);
            req_valid = 1'b0;
            return;
        end
        @(negedge clk);
        req_valid = 1'b0;
        cycles = 0;
        ready_at = -1;
        while (!resp_valid && cycles < resp_limit) begin
            if (req_ready && ready_at < 0)
                ready_at = cycles;
            @(negedge clk);
            cycles++;
        end
        if (req_ready && ready_at < 0)
            ready_at = cycles;
        ops_done++;
        if (!resp_valid) begin
            errors++;
            $display("%s got no response within %0d cycles", ctx, resp_limit);
            return;
        end
        check_cycles(cycles, exp_lat, {ctx, " response latency"});
        check_cycles(ready_at, exp_err ? 1 : exp_lat, {ctx, " req_ready return"});
        check_data(resp_data, exp_data, {ctx, " result"});
        check_err(resp_err, exp_err, {ctx, " error flag"});
    endtask

    // req_valid stays high, a new operation goes out right after each acceptance
    task automatic run_mix(input int n_ops);
        word_t   exp_data_q [$];
        logic    exp_err_q [$];
        word_t   exp_data;
        logic    exp_err;
        mem_op_e op;
        addr_t   a;
        word_t   d;
        int      sent;
        int      got;
        int      guard;
        logic    accept;
        sent  = 0;
        got   = 0;
        guard = 0;
        @(negedge clk);
        pick_random_op(op, a, d);
        drive_req(op, a, d);
        while (got < n_ops && guard < n_ops * (mem_delay + 4) + 100) begin
            accept = req_valid && req_ready;
            if (accept) begin
                model_apply(req_op, req_addr, req_wdata, exp_data, exp_err);
                exp_data_q.push_back(exp_data);
                exp_err_q.push_back(exp_err);
                sent++;
            end
            @(negedge clk);
            guard++;
            if (resp_valid && exp_data_q.size() == 0) begin
                errors++;
                $display("response at %0t arrived with no operation outstanding", $time);
            end else if (resp_valid) begin
                check_data(resp_data, exp_data_q.pop_front(), "mixed stream result");
                check_err(resp_err, exp_err_q.pop_front(), "mixed stream error flag");
            end
            if (resp_valid)
                got++;
            if (accept && sent < n_ops) begin
                pick_random_op(op, a, d);
                drive_req(op, a, d);
            end else if (accept) begin
                req_valid = 1'b0;
            end
        end
        req_valid = 1'b0;
        ops_done += sent;
        if (got < n_ops) begin
            errors++;
            $display("mixed stream stalled after %0d of %0d responses", got, n_ops);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%-18s %0d operations, %0d errors", name, ops_done - op_mark, errors - err_mark);
        op_mark  = ops_done;
        err_mark = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [1:0]  off;
        mem_op_e     op;
        addr_t       a;
        rng_state = 32'd57;
        errors    = 0;
        checks    = 0;
        ops_done  = 0;
        tests_run = 0;
        op_mark   = 0;
        err_mark  = 0;
        hold_rst  = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_LW;
        req_addr  = '0;
        req_wdata = '0;
        oob_wen   = 1'b0;
        oob_addr  = '0;
        oob_data  = '0;

        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            @(negedge clk);
            oob_wen  = 1'b1;
            oob_addr = addr_t'(i); // preload port takes a word index
            oob_data = lcg_next();
            model_mem[i] = oob_data;
        end
        @(negedge clk);
        oob_wen  = 1'b0;
        hold_rst = 1'b0;
        wait (rst == 1'b0);

        for (int i = 0; i < `LSU_MEM_WORDS; i++)
            run_op(OP_LW, addr_t'(i) << 2, '0);
        end_test("preload readback");

        for (int i = 0; i < n_pairs; i++) begin
            a = rand_word_addr();
            run_op(OP_SW, a, lcg_next());
            run_op(OP_LW, a, '0);
        end
        end_test("store then load");

        for (int i = 0; i < n_sub; i++) begin
            r   = lcg_next();
            op  = sub_ops[r[17:16]];
            off = r[21:20];
            if (op == OP_LH || op == OP_LHU)
                off[0] = 1'b0;
            run_op(op, rand_word_addr() | addr_t'(off), '0);
        end
        end_test("sub-word loads");

        for (int i = 0; i < n_mis; i++) begin
            r   = lcg_next();
            op  = mis_ops[r[17:16]];
            off = (op == OP_LH || op == OP_LHU) ? {r[20], 1'b1} : r[21:20];
            if (off == 2'b00)
                off = 2'b11;
            a = rand_word_addr();
            run_op(op, a | addr_t'(off), lcg_next());
            run_op(OP_LW, a, '0); // word must be untouched
        end
        end_test("misaligned");

        run_mix(n_mix);
        end_test("back-to-back mix");

        errors += i_lsu_top.i_chk.fail_count;
        $display("%0d tests, %0d operations, %0d checks, %0d assertion failures, %0d errors",
                 tests_run, ops_done, checks, i_lsu_top.i_chk.fail_count, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(wd_cycles * 20);
        $display("watchdog expired after %0d cycles, the run did not complete", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== tests/lsu_chk.sv ====
`timescale 1ns/1ps

module lsu_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  rd_req,
    input logic                  wr_req,
    input logic                  busy,
    input logic                  ack,
    input logic                  resp_valid,
    input logic                  req_ready,
    input lsu_pkg::issue_state_e issue_state
);
    import lsu_pkg::*;

    int fail_count = 0; // number of assertion failures so far

    a_strobe_idle: assert property (@(posedge clk) disable iff (rst)
        (rd_req || wr_req) |-> !busy)
        else begin
            $error("memory strobe raised while the memory is busy");
            fail_count++;
        end

    a_ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else begin
            $error("ack stayed high for more than one cycle");
            fail_count++;
        end

    // every memory answer turns into a response one cycle later
    a_resp_after_ack: assert property (@(posedge clk) disable iff (rst) ack |=> resp_valid)
        else begin
            $error("resp_valid did not follow ack");
            fail_count++;
        end

    // the issue stage only gets back to idle on ack or straight after a misaligned tag
    a_ready_return: assert property (@(posedge clk) disable iff (rst)
        $rose(req_ready) |-> $past(ack || (issue_state == ISSUE_SEND)))
        else begin
            $error("req_ready returned high without ack or a misaligned tag");
            fail_count++;
        end

endmodule

bind lsu_top lsu_chk i_chk (
    .clk         (clk),
    .rst         (rst),
    .rd_req      (mem_bus.rd_req),
    .wr_req      (mem_bus.wr_req),
    .busy        (mem_bus.busy),
    .ack         (mem_bus.ack),
    .resp_valid  (resp_valid),
    .req_ready   (req_ready),
    .issue_state (i_issue.state_q)
);

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns  = 20,
    parameter int rst_cycles = 16
) (
    output logic clk,
    output logic rst,
    input  logic hold_rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset lasts at least rst_cycles and stretches while the preload still runs
    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        while (hold_rst) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top #(
    parameter int mem_delay = `LSU_MEM_DELAY
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  lsu_pkg::mem_op_e req_op,
    input  lsu_pkg::addr_t   req_addr,
    input  lsu_pkg::word_t   req_wdata,
    output logic             req_ready,
    output logic             resp_valid,
    output lsu_pkg::word_t   resp_data,
    output logic             resp_err,
    input  logic             oob_wen,
    input  lsu_pkg::addr_t   oob_addr,
    input  lsu_pkg::word_t   oob_data
);

    mem_req_if mem_bus ();
    lsu_tag_if tag_bus ();

    lsu_issue i_issue (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .mem       (mem_bus.requester),
        .tag       (tag_bus.source)
    );

    mem_delayed #(
        .mem_delay (mem_delay)
    ) i_mem (
        .clk      (clk),
        .rst      (rst),
        .bus      (mem_bus.memory),
        .oob_wen  (oob_wen),
        .oob_addr (oob_addr),
        .oob_data (oob_data)
    );

    // read data and ack go straight to the formatter, the issue stage only needs ack
    lsu_format i_format (
        .clk         (clk),
        .rst         (rst),
        .tag         (tag_bus.sink),
        .mem_ack     (mem_bus.ack),
        .mem_rd_data (mem_bus.rd_data),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_err    (resp_err)
    );

endmodule

// ==== hdl/lsu_format.sv ====
`timescale 1ns/1ps

module lsu_format (
    input  logic           clk,
    input  logic           rst,
    lsu_tag_if.sink        tag,
    input  logic           mem_ack,
    input  lsu_pkg::word_t mem_rd_data,
    output logic           resp_valid,
    output lsu_pkg::word_t resp_data,
    output logic           resp_err
);
    import lsu_pkg::*;

    logic       pend_q;
    mem_op_e    op_q;
    logic [1:0] off_q;
    logic       mis_q;

    logic        done;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    word_t       result;

    // a misaligned tag is answered one cycle after it arrives, others wait for ack
    assign done = pend_q && (mis_q || mem_ack);

    // little-endian lanes
    assign lane_b = mem_rd_data[8*off_q +: 8];
    assign lane_h = off_q[1] ? mem_rd_data[31:16] : mem_rd_data[15:0];

    always_comb begin
        case (op_q)
            OP_LB:   result = {{24{lane_b[7]}}, lane_b};
            OP_LBU:  result = {24'b0, lane_b};
            OP_LH:   result = {{16{lane_h[15]}}, lane_h};
            OP_LHU:  result = {16'b0, lane_h};
            OP_LW:   result = mem_rd_data;
            default: result = '0; // stores answer with zero
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_q     <= 1'b0;
            resp_valid <= 1'b0;
            resp_err   <= 1'b0;
        end else begin
            if (tag.valid) begin
                pend_q <= 1'b1;
            end else if (done) begin
                pend_q <= 1'b0;
            end
            resp_valid <= done;
            resp_err   <= done && mis_q;
        end
    end

    always_ff @(posedge clk) begin
        if (tag.valid) begin
            op_q  <= tag.op;
            off_q <= tag.byte_off;
            mis_q <= tag.misaligned;
        end
        if (done) begin
            resp_data <= mis_q ? '0 : result;
        end
    end

endmodule

// ==== hdl/mem_delayed.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module mem_delayed #(
    parameter int mem_delay = `LSU_MEM_DELAY
) (
    input  logic           clk,
    input  logic           rst,
    mem_req_if.memory      bus,
    input  logic           oob_wen,
    input  lsu_pkg::addr_t oob_addr,
    input  lsu_pkg::word_t oob_data
);
    import lsu_pkg::*;

    localparam int idx_w = $clog2(`LSU_MEM_WORDS);
    localparam int cnt_w = $clog2(mem_delay + 2);

    word_t mem [`LSU_MEM_WORDS];

    logic             pend_rd;
    logic             pend_wr;
    logic [cnt_w-1:0] cnt;
    logic [idx_w-1:0] req_idx;
    word_t            req_data;

    logic pending;
    logic fire;

    assign pending = pend_rd || pend_wr;
    assign fire    = pending && (cnt == '0); // countdown done, access happens now

    // one request at a time, new strobes are only looked at when idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_rd  <= 1'b0;
            pend_wr  <= 1'b0;
            cnt      <= '0;
            bus.busy <= 1'b0;
            bus.ack  <= 1'b0;
        end else begin
            bus.ack <= 1'b0;
            if (pending) begin
                if (fire) begin
                    bus.ack  <= 1'b1;
                    bus.busy <= 1'b0;
                    pend_rd  <= 1'b0;
                    pend_wr  <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end else if (bus.wr_req || bus.rd_req) begin
                pend_wr  <= bus.wr_req;
                pend_rd  <= bus.rd_req && !bus.wr_req; // a write wins if both show up
                cnt      <= cnt_w'(mem_delay);
                bus.busy <= 1'b1;
            end
        end
    end

    // word index comes from the bits above the byte offset
    always_ff @(posedge clk) begin
        if (!pending && (bus.wr_req || bus.rd_req)) begin
            req_idx  <= bus.addr[idx_w+1:2];
            req_data <= bus.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // preload port, oob_addr is already a word index
            if (oob_wen) begin
                mem[oob_addr[idx_w-1:0]] <= oob_data;
            end
        end else if (fire && pend_wr) begin
            mem[req_idx] <= req_data;
        end
        bus.rd_data <= (fire && pend_rd) ? mem[req_idx] : '0;
    end

endmodule

// ==== hdl/lsu_issue.sv ====
`timescale 1ns/1ps

module lsu_issue (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  lsu_pkg::mem_op_e req_op,
    input  lsu_pkg::addr_t  req_addr,
    input  lsu_pkg::word_t  req_wdata,
    output logic            req_ready,
    mem_req_if.requester    mem,
    lsu_tag_if.source       tag
);
    import lsu_pkg::*;

    issue_state_e state_q;
    issue_state_e state_d;

    mem_op_e op_q;
    addr_t   addr_q;
    word_t   wdata_q;
    logic    mis_q;

    // halfwords need an even offset, words and stores a zero offset
    function automatic logic is_misaligned(mem_op_e op, logic [1:0] off);
        logic mis;
        case (op)
            OP_LH, OP_LHU: mis = off[0];
            OP_LW, OP_SW:  mis = (off != 2'b00);
            default:       mis = 1'b0;
        endcase
        return mis;
    endfunction

    assign req_ready = (state_q == ISSUE_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ISSUE_IDLE: if (req_valid) state_d = ISSUE_SEND;
            ISSUE_SEND: state_d = mis_q ? ISSUE_IDLE : ISSUE_WAIT; // a bad address never waits
            ISSUE_WAIT: if (mem.ack) state_d = ISSUE_IDLE;
            default:    state_d = ISSUE_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ISSUE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            op_q    <= req_op;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            mis_q   <= is_misaligned(req_op, req_addr[1:0]);
        end
    end

    // exactly one strobe per accepted operation, and none if misaligned
    assign mem.rd_req  = (state_q == ISSUE_SEND) && !mis_q && (op_q != OP_SW);
    assign mem.wr_req  = (state_q == ISSUE_SEND) && !mis_q && (op_q == OP_SW);
    assign mem.addr    = addr_q;
    assign mem.wr_data = wdata_q;

    assign tag.valid      = (state_q == ISSUE_SEND);
    assign tag.op         = op_q;
    assign tag.byte_off   = addr_q[1:0];
    assign tag.misaligned = mis_q;

endmodule

// ==== hdl/lsu_tag_if.sv ====
`timescale 1ns/1ps

interface lsu_tag_if;
    import lsu_pkg::*;

    logic       valid; // one cycle, alongside the memory strobe
    mem_op_e    op;
    logic [1:0] byte_off;
    logic       misaligned;

    modport source (
        output valid, op, byte_off, misaligned
    );

    modport sink (
        input valid, op, byte_off, misaligned
    );

endinterface

// ==== hdl/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if;
    import lsu_pkg::*;

    logic  rd_req;
    logic  wr_req;
    addr_t addr;    // byte address, the memory drops the low two bits
    word_t wr_data;
    word_t rd_data; // only meaningful while ack is high
    logic  busy;
    logic  ack;

    modport requester (
        output rd_req, wr_req, addr, wr_data,
        input  busy, ack, rd_data
    );

    modport memory (
        input  rd_req, wr_req, addr, wr_data,
        output busy, ack, rd_data
    );

endinterface

// ==== hdl/lsu_pkg.sv ====
`include "lsu_consts.svh"

package lsu_pkg;

    typedef logic [`LSU_ADDR_W-1:0] addr_t; // byte address
    typedef logic [`LSU_DATA_W-1:0] word_t;

    // loads come in signed and unsigned flavours, stores are whole words only
    typedef enum logic [2:0] {
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SW
    } mem_op_e;

    // issue stage sequencing
    typedef enum logic [1:0] {
        ISSUE_IDLE,
        ISSUE_SEND,
        ISSUE_WAIT
    } issue_state_e;

endpackage

// ==== include/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// byte address width seen by the core
`define LSU_ADDR_W 32

// data path width
`define LSU_DATA_W 32

// depth of the backing memory in 32-bit words
`define LSU_MEM_WORDS 256

// cycles the memory counts down before it answers
`define LSU_MEM_DELAY 5

`endif
